/* src.f */
cpu_pkg.sv
cpu_control.sv
cpu_fetch.sv
cpu_decode.sv
cpu_execute.sv
cpu_memory.sv
cpu_top.sv
tb_cpu_sva.sv
tb_cpu.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timing --timescale 1ns/1ps --top-module tb_cpu -f src.f \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vtb_cpu > sim.log 2>&1
cat sim.log
grep -qx "TEST OK" sim.log && exit 0 || { echo "Simulation did not pass"; exit 1; }

/* tb_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu
    import cpu_pkg::*;
();

    localparam int          MEM_WORDS     = 256;
    localparam int          RESET_CYCLES  = 16;
    localparam int          CYCLES_PER_OP = 64;
    localparam int          MAX_STEPS     = 1000;
    localparam int          POST_HALT     = 20;
    localparam int          STORE_TESTS   = 4;
    localparam logic [31:0] LFSR_SEED     = 32'h4da2e804;
    localparam logic [31:0] LFSR_TAPS     = 32'h80200003;

    logic            i_clock;
    logic            i_arst_n;
    logic            o_bus_request;
    bus_req_t        o_bus_cmd;
    logic            i_bus_ready = 1'b0;
    logic [XLEN-1:0] i_bus_rdata = '0;
    logic            o_halted;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] ref_mem [MEM_WORDS];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] lfsr_state = LFSR_SEED;
    logic        pending = 1'b0;
    logic        timed_out = 1'b0;
    int          delay_left = 0;
    int          zero_delays = 0;
    int          long_delays = 0;
    int          write_count = 0;
    int          errors = 0;
    int          errors_at_test_start = 0;
    int          tests_done = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          expected_instructions = 0;
    int          test_last_store [STORE_TESTS] = '{6, 8, 9, 13}; // Store count that ends a test.
    string       test_names [6] = '{"R-type ALU results", "ADDI sign and register 0",
                                    "Load then store", "BNE loop and untaken BEQ",
                                    "Random bus latency", "Halt and store count"};

    initial begin
        i_clock = 1'b0;
        forever #10 i_clock = ~i_clock;
    end

    cpu_top uut (
        .i_clock(i_clock), .i_arst_n(i_arst_n), .o_bus_request(o_bus_request),
        .o_bus_cmd(o_bus_cmd), .i_bus_ready(i_bus_ready), .i_bus_rdata(i_bus_rdata),
        .o_halted(o_halted)
    );

    // ##################################################################
    // Helpers
    // ##################################################################

    function automatic logic lfsr_bit();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ LFSR_TAPS;
        end
        return out;
    endfunction

    function automatic int random_delay();
        int delay;
        delay = 0;
        for (int b = 0; b < 3; b++) begin
            delay = (delay << 1) | int'(lfsr_bit()); // Three bits give 0 to 7 cycles.
        end
        return delay;
    endfunction

    function automatic logic [31:0] r_type_word(funct_e funct, int rd, int rs1, int rs2);
        return {OP_RTYPE, rd[4:0], rs1[4:0], rs2[4:0], 5'd0, funct};
    endfunction

    function automatic logic [31:0] i_type_word(opcode_e op, int rd, int rs1, int imm);
        return {op, rd[4:0], rs1[4:0], imm[15:0]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, expected);
            errors++;
        end
    endtask

    task automatic finish_test();
        if (errors == errors_at_test_start) begin
            $display("Test %0d, %s: passed", tests_done + 1, test_names[tests_done]);
            tests_passed++;
        end else begin
            $display("Test %0d, %s: failed", tests_done + 1, test_names[tests_done]);
            tests_failed++;
        end
        errors_at_test_start = errors;
        tests_done++;
    endtask

    task automatic load_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h96, 8'h3c};
        end
        mem[0]   = i_type_word(OP_ADDI, 1, 0, -7);
        mem[1]   = i_type_word(OP_ADDI, 2, 0, 12);
        mem[2]   = r_type_word(F_ADD, 3, 1, 2);
        mem[3]   = r_type_word(F_SUB, 4, 1, 2);
        mem[4]   = r_type_word(F_AND, 5, 1, 2);
        mem[5]   = r_type_word(F_OR, 6, 1, 2);
        mem[6]   = r_type_word(F_XOR, 7, 1, 2);
        mem[7]   = r_type_word(F_SLT, 8, 1, 2);
        mem[8]   = i_type_word(OP_SW, 3, 0, 'h200);
        mem[9]   = i_type_word(OP_SW, 4, 0, 'h204);
        mem[10]  = i_type_word(OP_SW, 5, 0, 'h208);
        mem[11]  = i_type_word(OP_SW, 6, 0, 'h20c);
        mem[12]  = i_type_word(OP_SW, 7, 0, 'h210);
        mem[13]  = i_type_word(OP_SW, 8, 0, 'h214);
        mem[14]  = i_type_word(OP_ADDI, 0, 0, 99);     // Lost in register 0.
        mem[15]  = i_type_word(OP_ADDI, 9, 1, -32768);
        mem[16]  = i_type_word(OP_SW, 0, 0, 'h218);
        mem[17]  = i_type_word(OP_SW, 9, 0, 'h21c);
        mem[18]  = i_type_word(OP_LW, 10, 0, 'h300);
        mem[19]  = i_type_word(OP_SW, 10, 0, 'h220);
        mem[20]  = i_type_word(OP_ADDI, 11, 0, 3);     // Loop counter.
        mem[21]  = i_type_word(OP_ADDI, 12, 0, 'h240); // Store pointer.
        mem[22]  = r_type_word(F_ADD, 13, 13, 11);
        mem[23]  = i_type_word(OP_SW, 13, 12, 0);
        mem[24]  = i_type_word(OP_ADDI, 12, 12, 4);
        mem[25]  = i_type_word(OP_ADDI, 11, 11, -1);
        mem[26]  = i_type_word(OP_BNE, 11, 0, -5);     // Back to word 22.
        mem[27]  = i_type_word(OP_BEQ, 11, 1, 4);
        mem[28]  = 32'h44000000;                       // Opcode 6'h11 is undefined.
        mem[29]  = i_type_word(OP_SW, 8, 0, 'h250);
        mem[30]  = {OP_HALT, 26'd0};
        mem[31]  = i_type_word(OP_SW, 1, 0, 'h254);    // Never reached.
        mem[192] = 32'hcafe_f00d;
    endtask

    function automatic int run_reference();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] word;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] src;
        logic [31:0] imm;
        logic [31:0] addr;
        logic [4:0]  rd;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc    = '0;
        steps = 0;
        while (steps < MAX_STEPS) begin
            word = ref_mem[pc[9:2]];
            rd   = word[25:21];
            a    = regs[word[20:16]];
            b    = regs[word[15:11]];
            src  = regs[rd];
            imm  = {{16{word[15]}}, word[15:0]};
            addr = a + imm;
            pc   = pc + 32'd4;
            steps++;
            case (word[31:26])
                OP_RTYPE: begin
                    case (word[5:0])
                        F_ADD:   regs[rd] = a + b;
                        F_SUB:   regs[rd] = a - b;
                        F_AND:   regs[rd] = a & b;
                        F_OR:    regs[rd] = a | b;
                        F_XOR:   regs[rd] = a ^ b;
                        F_SLT:   regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: regs[rd] = '0;
                    endcase
                end
                OP_ADDI: regs[rd] = addr;
                OP_LW:   regs[rd] = ref_mem[addr[9:2]];
                OP_SW: begin
                    ref_mem[addr[9:2]] = src;
                    exp_addr.push_back(addr);
                    exp_data.push_back(src);
                end
                OP_BEQ:  if (src == a) pc = pc + (imm << 2);
                OP_BNE:  if (src != a) pc = pc + (imm << 2);
                OP_HALT: return steps;
                default: ;
            endcase
            regs[0] = '0;
        end
        return steps;
    endfunction

    // ##################################################################
    // Bus memory model and write monitor
    // ##################################################################

    always @(negedge i_clock) begin
        if (!i_arst_n) begin
            i_bus_ready <= 1'b0;
            pending = 1'b0;
        end else if (i_bus_ready) begin
            i_bus_ready <= 1'b0; // Taken on the rising edge just passed.
        end else if (o_bus_request) begin
            if (!pending) begin
                pending    = 1'b1;
                delay_left = random_delay();
                zero_delays += (delay_left == 0) ? 1 : 0;
                long_delays += (delay_left >= 6) ? 1 : 0;
            end
            if (delay_left == 0) begin
                pending = 1'b0;
                i_bus_ready <= 1'b1;
                i_bus_rdata <= mem[o_bus_cmd.address[9:2]];
                if (o_bus_cmd.rw) begin
                    mem[o_bus_cmd.address[9:2]] = o_bus_cmd.wdata;
                end
            end else begin
                delay_left--;
            end
        end
    end

    always @(posedge i_clock) begin
        if (i_arst_n && o_bus_request && i_bus_ready && o_bus_cmd.rw) begin
            if (write_count < exp_addr.size()) begin
                check_value("o_bus_cmd.address", o_bus_cmd.address, exp_addr[write_count]);
                check_value("o_bus_cmd.wdata", o_bus_cmd.wdata, exp_data[write_count]);
            end else begin
                $display("A write to 0x%08h came after the last expected store",
                         o_bus_cmd.address);
                errors++;
            end
            write_count++;
            if (tests_done < STORE_TESTS && write_count == test_last_store[tests_done]) begin
                finish_test();
            end
        end
        if (i_arst_n && o_halted && o_bus_request) begin
            $display("A bus request was raised after the core halted");
            errors++;
        end
    end

    // ##################################################################
    // Run
    // ##################################################################

    initial begin
        i_arst_n = 1'b0;
        load_program();
        ref_mem = mem;
        expected_instructions = run_reference();
        cycle_limit = CYCLES_PER_OP * expected_instructions + RESET_CYCLES;
        repeat (RESET_CYCLES) @(negedge i_clock);
        i_arst_n    = 1'b1;
        cycle_count = RESET_CYCLES;
        while (!o_halted && !timed_out) begin
            @(negedge i_clock);
            cycle_count++;
            timed_out = (cycle_count >= cycle_limit);
        end
        if (timed_out) begin
            $display("Timeout: the core did not halt within %0d cycles", cycle_limit);
            errors++;
        end else begin
            repeat (POST_HALT) @(negedge i_clock);
            if (tests_done < STORE_TESTS) begin
                $display("Only %0d of %0d expected stores were seen", write_count,
                         exp_addr.size());
                errors++;
            end
            while (tests_done < STORE_TESTS) begin
                finish_test();
            end
            if (zero_delays == 0 || long_delays == 0) begin
                $display("The bus latency range from 0 to 7 cycles was not covered");
                errors++;
            end
            finish_test();
            check_value("o_halted", 32'(o_halted), 32'd1);
            check_value("write count", 32'(write_count), 32'(exp_addr.size()));
            for (int i = 0; i < MEM_WORDS; i++) begin
                check_value($sformatf("mem[%0d]", i), mem[i], ref_mem[i]);
            end
            finish_test();
        end
        $display("Tests passed %0d, failed %0d, errors %0d, cycles %0d", tests_passed,
                 tests_failed, errors, cycle_count);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb_cpu_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_sva
    import cpu_pkg::*;
(
    input wire logic     i_clock,
    input wire logic     i_arst_n,
    input wire logic     i_bus_request,
    input wire bus_req_t i_bus_cmd,
    input wire logic     i_bus_ready,
    input wire logic     i_halted
);

    // A request not yet accepted stays up with the same command.
    property request_held;
        @(posedge i_clock) disable iff (!i_arst_n)
            i_bus_request && !i_bus_ready |=> i_bus_request && $stable(i_bus_cmd);
    endproperty

    assert property (request_held)
        else $error("Bus request dropped or its command changed before ready");

    assert property (@(posedge i_clock) disable iff (!i_arst_n) i_halted |-> !i_bus_request)
        else $error("Bus request raised while the core is halted");

    assert property (@(posedge i_clock) $rose(i_arst_n) |-> !i_bus_request)
        else $error("Bus request high in the first cycle after reset");

endmodule

bind cpu_top tb_cpu_sva u_sva (
    .i_clock(i_clock), .i_arst_n(i_arst_n), .i_bus_request(o_bus_request),
    .i_bus_cmd(o_bus_cmd), .i_bus_ready(i_bus_ready), .i_halted(o_halted)
);

`default_nettype wire

/* cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top
    import cpu_pkg::*;
(
    input  wire logic            i_clock,
    input  wire logic            i_arst_n,
    output logic                 o_bus_request,
    output bus_req_t             o_bus_cmd,
    input  wire logic            i_bus_ready,
    input  wire logic [XLEN-1:0] i_bus_rdata,
    output logic                 o_halted
);

    logic            fetch_start;
    logic            exec_start;
    logic            mem_start;
    logic            writeback;
    logic            fetch_done;
    logic            mem_done;
    logic            fetch_request;
    logic            mem_request;
    logic            fetch_bus_ready;
    logic            mem_bus_ready;
    bus_req_t        fetch_cmd;
    bus_req_t        mem_cmd;
    inst_u           instruction;
    logic [XLEN-1:0] pc;
    dec_out_t        dec;
    opcode_e         opcode;
    exe_out_t        exe;
    mem_out_t        mem_out;

    cpu_control u_control (
        .i_clock(i_clock), .i_arst_n(i_arst_n),
        .i_fetch_done(fetch_done), .i_mem_done(mem_done), .i_opcode(opcode),
        .i_fetch_request(fetch_request), .i_fetch_cmd(fetch_cmd),
        .i_mem_request(mem_request), .i_mem_cmd(mem_cmd), .i_bus_ready(i_bus_ready),
        .o_fetch_start(fetch_start), .o_exec_start(exec_start), .o_mem_start(mem_start),
        .o_writeback(writeback), .o_fetch_bus_ready(fetch_bus_ready),
        .o_mem_bus_ready(mem_bus_ready), .o_bus_request(o_bus_request),
        .o_bus_cmd(o_bus_cmd), .o_halted(o_halted)
    );

    cpu_fetch u_fetch (
        .i_clock(i_clock), .i_arst_n(i_arst_n), .i_fetch_start(fetch_start),
        .i_bus_ready(fetch_bus_ready), .i_bus_rdata(i_bus_rdata),
        .i_writeback(writeback), .i_mem_out(mem_out),
        .o_request(fetch_request), .o_cmd(fetch_cmd), .o_instruction(instruction),
        .o_pc(pc), .o_fetch_done(fetch_done)
    );

    cpu_decode u_decode (
        .i_clock(i_clock), .i_arst_n(i_arst_n), .i_instruction(instruction), .i_pc(pc),
        .i_writeback(writeback), .i_mem_out(mem_out), .o_dec(dec), .o_opcode(opcode)
    );

    cpu_execute u_execute (
        .i_clock(i_clock), .i_arst_n(i_arst_n), .i_exec_start(exec_start),
        .i_dec(dec), .o_exe(exe)
    );

    cpu_memory u_memory (
        .i_clock(i_clock), .i_arst_n(i_arst_n), .i_mem_start(mem_start), .i_exe(exe),
        .i_bus_ready(mem_bus_ready), .i_bus_rdata(i_bus_rdata),
        .o_request(mem_request), .o_cmd(mem_cmd), .o_mem_out(mem_out),
        .o_mem_done(mem_done)
    );

endmodule

`default_nettype wire

/* cpu_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_memory
    import cpu_pkg::*;
(
    input  wire logic            i_clock,
    input  wire logic            i_arst_n,
    input  wire logic            i_mem_start,
    input  wire exe_out_t        i_exe,
    input  wire logic            i_bus_ready,
    input  wire logic [XLEN-1:0] i_bus_rdata,
    output logic                 o_request,
    output bus_req_t             o_cmd,
    output mem_out_t             o_mem_out,
    output logic                 o_mem_done
);

    logic accept;

    assign accept = o_request && i_bus_ready; // Transaction closes on this edge.

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_request  <= 1'b0;
            o_mem_done <= 1'b0;
        end else begin
            o_mem_done <= 1'b0;
            if (accept) begin
                o_request  <= 1'b0;
                o_mem_done <= 1'b1;
            end
            if (i_mem_start) begin
                if (i_exe.mem_read || i_exe.mem_write) begin
                    o_request <= 1'b1;
                end else begin
                    o_mem_done <= 1'b1; // No access, done at once.
                end
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_mem_start) begin
            o_mem_out.rd       <= i_exe.rd;
            o_mem_out.rd_value <= i_exe.result;
            o_mem_out.branch   <= i_exe.branch;
            o_mem_out.pc_next  <= i_exe.pc_next;
            o_cmd.rw           <= i_exe.mem_write;
            o_cmd.address      <= i_exe.mem_address;
            o_cmd.wdata        <= i_exe.store_data;
        end else if (accept && !o_cmd.rw) begin
            o_mem_out.rd_value <= i_bus_rdata;
        end
    end

endmodule

`default_nettype wire

/* cpu_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_execute
    import cpu_pkg::*;
(
    input  wire logic     i_clock,
    input  wire logic     i_arst_n,
    input  wire logic     i_exec_start,
    input  wire dec_out_t i_dec,
    output exe_out_t      o_exe
);

    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] sum_imm;
    logic [XLEN-1:0] branch_target;
    logic            less_than;
    exe_out_t        exe_next;

    assign less_than = $signed(i_dec.value_a) < $signed(i_dec.value_b);

    always_comb begin
        case (i_dec.funct)
            F_ADD:   alu_result = i_dec.value_a + i_dec.value_b;
            F_SUB:   alu_result = i_dec.value_a - i_dec.value_b;
            F_AND:   alu_result = i_dec.value_a & i_dec.value_b;
            F_OR:    alu_result = i_dec.value_a | i_dec.value_b;
            F_XOR:   alu_result = i_dec.value_a ^ i_dec.value_b;
            F_SLT:   alu_result = {{(XLEN-1){1'b0}}, less_than};
            default: alu_result = '0;
        endcase
    end

    assign sum_imm       = i_dec.value_a + i_dec.imm; // ADDI result and LW/SW address.
    assign branch_target = i_dec.pc + PC_STEP + {i_dec.imm[XLEN-3:0], 2'b00};

    always_comb begin
        exe_next             = '0;
        exe_next.pc_next     = branch_target;
        exe_next.mem_address = sum_imm;
        exe_next.store_data  = i_dec.value_b;
        case (i_dec.opcode)
            OP_RTYPE: begin
                exe_next.rd     = i_dec.rd;
                exe_next.result = alu_result;
            end
            OP_ADDI: begin
                exe_next.rd     = i_dec.rd;
                exe_next.result = sum_imm;
            end
            OP_LW: begin
                exe_next.rd       = i_dec.rd;
                exe_next.mem_read = 1'b1;
            end
            OP_SW:   exe_next.mem_write = 1'b1;
            OP_BEQ:  exe_next.branch = (i_dec.value_a == i_dec.value_b);
            OP_BNE:  exe_next.branch = (i_dec.value_a != i_dec.value_b);
            default: ; // HALT and unknown opcodes leave no trace.
        endcase
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_exe <= '0;
        end else if (i_exec_start) begin
            o_exe <= exe_next;
        end
    end

endmodule

`default_nettype wire

/* cpu_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_decode
    import cpu_pkg::*;
(
    input  wire logic            i_clock,
    input  wire logic            i_arst_n,
    input  wire inst_u           i_instruction,
    input  wire logic [XLEN-1:0] i_pc,
    input  wire logic            i_writeback,
    input  wire mem_out_t        i_mem_out,
    output dec_out_t             o_dec,
    output opcode_e              o_opcode
);

    logic [XLEN-1:0]       regs [NUM_REGS];
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] src_b;
    logic                  rd_is_source;
    logic [XLEN-1:0]       value_a;
    logic [XLEN-1:0]       value_b;

    // ##################################################################
    // Field split and operand read
    // ##################################################################

    assign o_opcode = i_instruction.r.opcode;
    assign rs1      = i_instruction.r.rs1;
    assign rd       = i_instruction.r.rd;

    // SW stores rd, and BEQ/BNE compare rd against rs1.
    assign rd_is_source = o_opcode inside {OP_SW, OP_BEQ, OP_BNE};
    assign src_b        = rd_is_source ? rd : i_instruction.r.rs2;

    assign value_a = (rs1 == '0) ? '0 : regs[rs1];
    assign value_b = (src_b == '0) ? '0 : regs[src_b]; // Register 0 is hardwired to zero.

    always_comb begin
        o_dec.opcode  = o_opcode;
        o_dec.funct   = i_instruction.r.funct;
        o_dec.rd      = rd;
        o_dec.value_a = value_a;
        o_dec.value_b = value_b;
        o_dec.imm     = {{(XLEN-IMM_W){i_instruction.i.imm[IMM_W-1]}}, i_instruction.i.imm};
        o_dec.pc      = i_pc;
    end

    // ##################################################################
    // Register file write port
    // ##################################################################

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_writeback && (i_mem_out.rd != '0)) begin
            regs[i_mem_out.rd] <= i_mem_out.rd_value;
        end
    end

endmodule

`default_nettype wire

/* cpu_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_fetch
    import cpu_pkg::*;
(
    input  wire logic            i_clock,
    input  wire logic            i_arst_n,
    input  wire logic            i_fetch_start,
    input  wire logic            i_bus_ready,
    input  wire logic [XLEN-1:0] i_bus_rdata,
    input  wire logic            i_writeback,
    input  wire mem_out_t        i_mem_out,
    output logic                 o_request,
    output bus_req_t             o_cmd,
    output inst_u                o_instruction,
    output logic [XLEN-1:0]      o_pc,
    output logic                 o_fetch_done
);

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_pc         <= '0;
            o_request    <= 1'b0;
            o_fetch_done <= 1'b0;
        end else begin
            o_fetch_done <= 1'b0;
            if (i_writeback) begin
                o_pc <= i_mem_out.branch ? i_mem_out.pc_next : o_pc + PC_STEP;
            end
            if (i_fetch_start) begin
                o_request <= 1'b1;
            end else if (o_request && i_bus_ready) begin
                o_request    <= 1'b0;
                o_fetch_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (o_request && i_bus_ready) begin
            o_instruction <= inst_u'(i_bus_rdata);
        end
    end

    // The pc only moves on writeback, so the address is stable while requesting.
    assign o_cmd = '{rw: 1'b0, address: o_pc, wdata: '0};

endmodule

`default_nettype wire

/* cpu_control.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_control
    import cpu_pkg::*;
(
    input  wire logic     i_clock,
    input  wire logic     i_arst_n,
    input  wire logic     i_fetch_done,
    input  wire logic     i_mem_done,
    input  wire opcode_e  i_opcode,
    input  wire logic     i_fetch_request,
    input  wire bus_req_t i_fetch_cmd,
    input  wire logic     i_mem_request,
    input  wire bus_req_t i_mem_cmd,
    input  wire logic     i_bus_ready,
    output logic          o_fetch_start,
    output logic          o_exec_start,
    output logic          o_mem_start,
    output logic          o_writeback,
    output logic          o_fetch_bus_ready,
    output logic          o_mem_bus_ready,
    output logic          o_bus_request,
    output bus_req_t      o_bus_cmd,
    output logic          o_halted
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_DECODE,
        S_EXECUTE,
        S_MEMORY,
        S_WRITEBACK,
        S_HALTED
    } state_e;

    state_e state;
    logic   mem_owner;

    // ##################################################################
    // Step sequencer
    // ##################################################################

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state         <= S_IDLE;
            o_fetch_start <= 1'b0;
            o_exec_start  <= 1'b0;
            o_mem_start   <= 1'b0;
            o_writeback   <= 1'b0;
            o_halted      <= 1'b0;
        end else begin
            o_fetch_start <= 1'b0;
            o_exec_start  <= 1'b0;
            o_mem_start   <= 1'b0;
            o_writeback   <= 1'b0;
            case (state)
                S_IDLE: begin
                    state         <= S_FETCH;
                    o_fetch_start <= 1'b1;
                end
                S_FETCH: begin
                    if (i_fetch_done) begin
                        state <= S_DECODE;
                    end
                end
                S_DECODE: begin
                    if (i_opcode == OP_HALT) begin
                        state    <= S_HALTED;
                        o_halted <= 1'b1;
                    end else begin
                        state        <= S_EXECUTE;
                        o_exec_start <= 1'b1;
                    end
                end
                S_EXECUTE: begin
                    state       <= S_MEMORY;
                    o_mem_start <= 1'b1;
                end
                S_MEMORY: begin
                    if (i_mem_done) begin
                        state         <= S_WRITEBACK;
                        o_writeback   <= 1'b1;
                        o_fetch_start <= 1'b1; // Request rises right after writeback.
                    end
                end
                S_WRITEBACK: state <= S_FETCH;
                S_HALTED:    state <= S_HALTED;
                default:     state <= S_IDLE;
            endcase
        end
    end

    // ##################################################################
    // Bus steering
    // ##################################################################

    assign mem_owner = (state == S_MEMORY); // Memory owns the bus only in its own step.

    assign o_bus_request     = mem_owner ? i_mem_request : i_fetch_request;
    assign o_bus_cmd         = mem_owner ? i_mem_cmd : i_fetch_cmd;
    assign o_fetch_bus_ready = i_bus_ready && !mem_owner;
    assign o_mem_bus_ready   = i_bus_ready && mem_owner;

endmodule

`default_nettype wire

/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    // ##################################################################
    // Sizes
    // ##################################################################

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int IMM_W      = 16;
    localparam int SHAMT_W    = 5;

    localparam logic [XLEN-1:0] PC_STEP = 32'd4; // One instruction word in bytes.

    // ##################################################################
    // Instruction encoding
    // ##################################################################

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b,
        OP_HALT  = 6'h3f
    } opcode_e;

    typedef enum logic [5:0] {
        F_ADD = 6'h20,
        F_SUB = 6'h22,
        F_AND = 6'h24,
        F_OR  = 6'h25,
        F_XOR = 6'h26,
        F_SLT = 6'h2a
    } funct_e;

    typedef struct packed {
        opcode_e                opcode;
        logic [REG_ADDR_W-1:0]  rd;
        logic [REG_ADDR_W-1:0]  rs1;
        logic [REG_ADDR_W-1:0]  rs2;
        logic [SHAMT_W-1:0]     shamt;  // Reserved, no shifts in this ISA.
        funct_e                 funct;
    } inst_r_t;

    typedef struct packed {
        opcode_e                opcode;
        logic [REG_ADDR_W-1:0]  rd;     // Source for SW and the compare operand of BEQ/BNE.
        logic [REG_ADDR_W-1:0]  rs1;
        logic [IMM_W-1:0]       imm;
    } inst_i_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_u;

    // ##################################################################
    // Step payloads and bus command
    // ##################################################################

    typedef struct packed {
        opcode_e                opcode;
        funct_e                 funct;
        logic [REG_ADDR_W-1:0]  rd;
        logic [XLEN-1:0]        value_a;
        logic [XLEN-1:0]        value_b;
        logic [XLEN-1:0]        imm;
        logic [XLEN-1:0]        pc;
    } dec_out_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0]  rd;
        logic [XLEN-1:0]        result;
        logic                   branch;
        logic [XLEN-1:0]        pc_next;
        logic                   mem_read;
        logic                   mem_write;
        logic [XLEN-1:0]        mem_address;
        logic [XLEN-1:0]        store_data;
    } exe_out_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0]  rd;     // Zero means nothing to write back.
        logic [XLEN-1:0]        rd_value;
        logic                   branch;
        logic [XLEN-1:0]        pc_next;
    } mem_out_t;

    typedef struct packed {
        logic                   rw;     // 1 is a write.
        logic [XLEN-1:0]        address;
        logic [XLEN-1:0]        wdata;
    } bus_req_t;

endpackage

`default_nettype wire
